// File: heartMonitor.f
verilog/heartPkg.sv
verilog/sampleReceiver.sv
verilog/firFilter.sv
verilog/peakDetector.sv
verilog/rateCounter.sv
verilog/dacSerializer.sv
verilog/rateDisplay.sv
verilog/heartMonitor.sv
tests/heartMonitor_assertions.sv
tests/heartMonitorChecker.sv
tests/heartMonitorTb.sv

// File: run.sh
#!/bin/sh
# build and run the heart-rate monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f heartMonitor.f --top-module heartMonitorTb -o heartSim

output=$(./obj_dir/heartSim) || true
echo "$output"

if echo "$output" | grep -qxF ">>> PASS"; then
	exit 0
else
	exit 1
fi

// File: tests/heartTests.txt
# name kind level period count rate
# level is the amplitude for triangle and the height for step
# period is the step position in samples for step, unused for constant
# rate is the expected display after the last window of count samples
flat500 constant 500 0 1200 0
flat1023 constant 1023 0 1200 0
step600 step 600 500 800 6
tri80 triangle 800 80 1200 30
tri100 triangle 800 100 1200 24

// File: tests/heartMonitorTb.sv
// testbench top, clock, reset, test file reader and serial frame stimulus
// per-test result lines and final summary
module heartMonitorTb;
	timeunit 1ns;
	timeprecision 1ps;
	import heartPkg::*;

	// cycles allowed for the last DAC word to come out
	localparam int WaitLimit = 100;

	logic sck;
	logic reset;
	logic sdo;
	logic dacData;
	logic dacLoad;
	logic peakLed;
	segT segOnes;
	segT segTens;
	segT segHundreds;
	logic flatInput;
	sampleT flatLevel;
	logic rateCheck;
	int expectedRate;
	int errorCount;
	int dacFrames;

	heartMonitor #(
		.WindowLen(32),
		.RiseLimit(6),
		.FallLimit(10),
		.HoldoffLen(20),
		.MeasureLen(400),
		.BeatScale(6)
	) dut (.sck, .reset, .sdo, .dacData, .dacLoad, .peakLed, .segOnes, .segTens, .segHundreds);

	heartMonitorChecker monitor (
		.sck, .reset, .sdo, .dacData, .dacLoad, .peakLed,
		.segOnes, .segTens, .segHundreds,
		.flatInput, .flatLevel, .rateCheck, .expectedRate,
		.errorCount, .dacFrames
	);

	always #5 sck = ~sck;

	task automatic applyReset();
		reset = 1'b1;
		repeat (5) @(posedge sck);
		#1 reset = 1'b0;
	endtask

	// one 16-bit frame, MSB first, sample in the low 10 bits
	task automatic sendFrame(input sampleT value);
		frameWordT word;
		word = {6'b0, value};
		for (int i = 15; i >= 0; i--)
		begin
			sdo = word[i];
			@(posedge sck);
			#1;
		end
	endtask

	function automatic sampleT waveValue(input string kind, input int level, input int period,
		input int i);
		int half;
		int phase;
		if (kind == "step")
			return (i < period) ? '0 : sampleT'(level);
		if (kind == "triangle")
		begin
			half = period / 2;
			phase = i % period;
			if (phase < half)
				return sampleT'(100 + level * phase / half);
			return sampleT'(100 + level * (period - phase) / half);
		end
		return sampleT'(level);
	endfunction

	task automatic waitFrames(input int count, output bit ok);
		int waited;
		waited = 0;
		while (dacFrames < count && waited < WaitLimit)
		begin
			@(posedge sck);
			waited++;
		end
		#1;
		ok = (dacFrames >= count);
	endtask

	int fd;
	string line;
	string name;
	string kind;
	int level;
	int period;
	int count;
	int rate;
	int errorsBefore;
	int testsRun = 0;
	int testsFailed = 0;
	bit ok;
	bit aborted = 1'b0;

	initial
	begin
		sck = 1'b0;
		reset = 1'b1;
		sdo = 1'b0;
		flatInput = 1'b0;
		flatLevel = '0;
		rateCheck = 1'b0;
		expectedRate = 0;
		fd = $fopen("tests/heartTests.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the test data file");
			aborted = 1'b1;
		end
		while (!aborted && !$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			// skip comments and blank lines
			if (line.len() < 2 || line.substr(0, 0) == "#")
				continue;
			if ($sscanf(line, "%s %s %d %d %d %d", name, kind, level, period, count, rate) != 6)
			begin
				$display("malformed test record: %s", line);
				aborted = 1'b1;
				continue;
			end
			errorsBefore = errorCount;
			flatInput = (kind == "constant");
			flatLevel = sampleT'(level);
			expectedRate = rate;
			applyReset();
			for (int i = 0; i < count; i++)
				sendFrame(waveValue(kind, level, period, i));
			sdo = 1'b0;
			waitFrames(count, ok);
			testsRun++;
			if (!ok)
			begin
				$display("test %s timed out waiting for DAC word %0d", name, count);
				testsFailed++;
				aborted = 1'b1;
				continue;
			end
			// compare the display once, after the last window
			rateCheck = 1'b1;
			@(posedge sck);
			#1 rateCheck = 1'b0;
			@(posedge sck);
			#1;
			if (errorCount != errorsBefore)
				testsFailed++;
			$display("test %s %s, %0d DAC words", name,
				(errorCount == errorsBefore) ? "ok" : "failed", dacFrames);
		end
		$display("%0d tests run, %0d failed, %0d check errors", testsRun, testsFailed, errorCount);
		if (!aborted && testsRun > 0 && testsFailed == 0 && errorCount == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: tests/heartMonitorChecker.sv
// watches the DUT ports, models the FIR filter from the serial input
// compares DAC words, reset state, flat-input behavior and the displayed rate
module heartMonitorChecker (
	input  logic             sck,
	input  logic             reset,
	input  logic             sdo,
	input  logic             dacData,
	input  logic             dacLoad,
	input  logic             peakLed,
	input  heartPkg::segT    segOnes,
	input  heartPkg::segT    segTens,
	input  heartPkg::segT    segHundreds,
	input  logic             flatInput,
	input  heartPkg::sampleT flatLevel,
	input  logic             rateCheck,
	input  int               expectedRate,
	output int               errorCount,
	output int               dacFrames
);
	timeunit 1ns;
	timeprecision 1ps;
	import heartPkg::*;

	// frames before the filter and hold-off have settled
	localparam int SettleFrames = 100;

	int errors = 0;
	int frames = 0;
	int taps [NumTaps];
	int bitCount = 0;
	frameWordT frame;
	dacWordT expectedQ [$];
	// last 11 DAC bits, oldest on top
	dacWordT history;
	dacWordT expectedWord;
	// first falling edge out of reset still to check
	bit released = 1'b0;

	assign errorCount = errors;
	assign dacFrames = frames;

	task automatic reportValue(input string name, input int expected, input int got);
		errors++;
		$display("CHECK FAILED t=%0t %s expected %0h got %0h", $time, name, expected, got);
	endtask

	// each coefficient weighs a mirrored pair, the centre tap once
	function automatic int firOutput();
		int sum;
		sum = FilterCoeffs[NumCoeffs - 1] * taps[NumCoeffs - 1];
		for (int k = 0; k < NumCoeffs - 1; k++)
			sum += FilterCoeffs[k] * (taps[k] + taps[NumTaps - 1 - k]);
		sum = sum >> FilterShift;
		return (sum > 1023) ? 1023 : sum;
	endfunction

	// steady-state filter output for a constant input
	function automatic int flatField();
		int gain;
		int level;
		gain = FilterCoeffs[NumCoeffs - 1];
		for (int k = 0; k < NumCoeffs - 1; k++)
			gain += 2 * FilterCoeffs[k];
		level = (int'(flatLevel) * gain) >> FilterShift;
		if (level > 1023)
			level = 1023;
		return level >> 2;
	endfunction

	function automatic int digitOf(input segT pattern);
		for (int d = 0; d < 10; d++)
			if (SegTable[d] == pattern)
				return d;
		return -1;
	endfunction

	// load high, led off, display at 000
	task automatic checkResetState();
		if (dacLoad !== 1'b1)
			reportValue("dacLoad", 1, dacLoad);
		if (peakLed !== 1'b0)
			reportValue("peakLed", 0, peakLed);
		if (segOnes !== SegTable[0])
			reportValue("segOnes", SegTable[0], segOnes);
		if (segTens !== SegTable[0])
			reportValue("segTens", SegTable[0], segTens);
		if (segHundreds !== SegTable[0])
			reportValue("segHundreds", SegTable[0], segHundreds);
	endtask

	task automatic checkRate();
		int h;
		int t;
		int o;
		h = digitOf(segHundreds);
		t = digitOf(segTens);
		o = digitOf(segOnes);
		if (h < 0 || t < 0 || o < 0)
		begin
			errors++;
			$display("t=%0t the display shows a pattern that is not a digit", $time);
		end
		else if (100 * h + 10 * t + o != expectedRate)
			reportValue("displayed rate", expectedRate, 100 * h + 10 * t + o);
	endtask

	// outputs settle after the rising edge, so sample on the falling one
	always @(negedge sck)
	begin
		if (reset)
		begin
			checkResetState();
			released = 1'b1;
			bitCount = 0;
			taps = '{default: 0};
			expectedQ.delete();
			history = '0;
			frames = 0;
		end
		else
		begin
			if (released)
			begin
				checkResetState();
				released = 1'b0;
			end
			// load low closes a word, the 11 bits before it are the data
			if (!dacLoad)
			begin
				frames++;
				if (expectedQ.size() == 0)
				begin
					errors++;
					$display("t=%0t a DAC word came out with no sample sent", $time);
				end
				else
				begin
					expectedWord = expectedQ.pop_front();
					if (history != expectedWord)
						reportValue("dacWord", expectedWord, history);
					if (flatInput && frames > SettleFrames && int'(history[7:0]) != flatField())
						reportValue("dac data field", flatField(), history[7:0]);
				end
			end
			history = {history[9:0], dacData};

			// own frame count, MSB first
			frame = {frame[14:0], sdo};
			bitCount++;
			if (bitCount == FrameLen)
			begin
				bitCount = 0;
				for (int i = 0; i < NumTaps - 1; i++)
					taps[i] = taps[i + 1];
				taps[NumTaps - 1] = int'(frame[9:0]);
				// channel and range bits are zero
				expectedQ.push_back({3'b000, 8'(firOutput() >> 2)});
			end

			if (flatInput && frames > SettleFrames && peakLed)
				reportValue("peakLed", 0, 1);
			if (rateCheck)
				checkRate();
		end
	end

endmodule

// File: tests/heartMonitor_assertions.sv
// bound checks on sample strobe spacing, DAC load pulse and LED hold time
module heartMonitorAssertions #(
	parameter int HoldoffLen = 256
) (
	input logic sck,
	input logic reset,
	input logic sampleStrobe,
	input logic filteredStrobe,
	input logic dacLoad,
	input logic peakLed
);
	timeunit 1ns;
	timeprecision 1ps;

	// cycles since the last sample strobe
	int strobeGap;
	bit strobeSeen;
	// filtered samples while the led is lit
	int ledSamples;

	always @(posedge sck or posedge reset)
	begin
		if (reset)
		begin
			strobeGap <= 0;
			strobeSeen <= 1'b0;
			ledSamples <= 0;
		end
		else
		begin
			if (sampleStrobe)
			begin
				strobeGap <= 0;
				strobeSeen <= 1'b1;
			end
			else
				strobeGap <= strobeGap + 1;
			if (!peakLed)
				ledSamples <= 0;
			else if (filteredStrobe)
				ledSamples <= ledSamples + 1;
		end
	end

	// one strobe per 16-cycle frame
	strobeSpacing: assert property (@(posedge sck) disable iff (reset)
		sampleStrobe && strobeSeen |-> strobeGap == 15)
		else $error("sample strobe spacing is not 16 cycles");

	strobeMissing: assert property (@(posedge sck) disable iff (reset)
		strobeSeen |-> strobeGap <= 15)
		else $error("sample strobe missing");

	loadSingle: assert property (@(posedge sck) disable iff (reset)
		!dacLoad |=> dacLoad)
		else $error("dacLoad low for more than one cycle");

	ledHold: assert property (@(posedge sck) disable iff (reset)
		$fell(peakLed) |-> ledSamples >= HoldoffLen)
		else $error("peakLed dropped before the hold-off ended");

endmodule

bind heartMonitor heartMonitorAssertions #(.HoldoffLen(HoldoffLen)) protocolChecks (
	.sck(sck),
	.reset(reset),
	.sampleStrobe(sampleStrobe),
	.filteredStrobe(filteredStrobe),
	.dacLoad(dacLoad),
	.peakLed(peakLed)
);

// File: verilog/heartMonitor.sv
// heart-rate monitor top level
// receiver, filter, peak detector, rate counter, DAC and display
module heartMonitor #(
	parameter int WindowLen  = 256,
	parameter int RiseLimit  = 60,
	parameter int FallLimit  = 60,
	parameter int HoldoffLen = 256,
	parameter int MeasureLen = 2000,
	parameter int BeatScale  = 6
) (
	input  logic          sck,
	input  logic          reset,
	input  logic          sdo,
	output logic          dacData,
	output logic          dacLoad,
	output logic          peakLed,
	output heartPkg::segT segOnes,
	output heartPkg::segT segTens,
	output heartPkg::segT segHundreds
);
	import heartPkg::*;

	sampleT sample;
	logic sampleStrobe;
	sampleT filtered;
	logic filteredStrobe;
	logic peakStrobe;
	rateT heartRate;
	logic rateStrobe;

	// one sample per 16-bit frame
	sampleReceiver receiver (.sck, .reset, .sdo, .sample, .sampleStrobe);

	firFilter filter (.sck, .reset, .sample, .sampleStrobe, .filtered, .filteredStrobe);

	peakDetector #(
		.WindowLen(WindowLen),
		.RiseLimit(RiseLimit),
		.FallLimit(FallLimit),
		.HoldoffLen(HoldoffLen)
	) detector (.sck, .reset, .filtered, .filteredStrobe, .peakStrobe, .peakLed);

	rateCounter #(
		.MeasureLen(MeasureLen),
		.BeatScale(BeatScale)
	) counter (.sck, .reset, .filteredStrobe, .peakStrobe, .heartRate, .rateStrobe);

	// filtered stream also goes straight to the DAC
	dacSerializer dac (.sck, .reset, .filtered, .filteredStrobe, .dacData, .dacLoad);

	rateDisplay display (
		.sck, .reset, .heartRate, .rateStrobe,
		.segOnes, .segTens, .segHundreds
	);

endmodule

// File: verilog/rateDisplay.sv
// three-digit static rate display
// clamp to 999, binary to BCD, seven-segment encoding
module rateDisplay (
	input  logic           sck,
	input  logic           reset,
	input  heartPkg::rateT heartRate,
	input  logic           rateStrobe,
	output heartPkg::segT  segOnes,
	output heartPkg::segT  segTens,
	output heartPkg::segT  segHundreds
);
	import heartPkg::*;

	localparam int BinW = 10;
	localparam int RateMax = 999;

	logic [BinW-1:0] clamped;
	// three BCD digits above the binary value
	logic [BinW+11:0] work;
	bcdT ones;
	bcdT tens;
	bcdT hundreds;

	// three digits only
	assign clamped = (heartRate > rateT'(RateMax)) ? BinW'(RateMax) : heartRate[BinW-1:0];

	// shift-and-add-three
	always_comb
	begin
		work = {12'b0, clamped};
		for (int i = 0; i < BinW; i++)
		begin
			for (int d = 0; d < 3; d++)
			begin
				if (work[BinW + 4 * d +: 4] >= 4'd5)
					work[BinW + 4 * d +: 4] = work[BinW + 4 * d +: 4] + 4'd3;
			end
			work = work << 1;
		end
	end

	assign ones = work[BinW +: 4];
	assign tens = work[BinW + 4 +: 4];
	assign hundreds = work[BinW + 8 +: 4];

	// display holds between windows, 000 out of reset
	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			segOnes <= SegTable[0];
			segTens <= SegTable[0];
			segHundreds <= SegTable[0];
		end
		else if (rateStrobe)
		begin
			segOnes <= SegTable[ones];
			segTens <= SegTable[tens];
			segHundreds <= SegTable[hundreds];
		end
	end

endmodule

// File: verilog/dacSerializer.sv
// serial DAC driver
// shifts out channel, range and 8 data bits, then pulses load low
module dacSerializer (
	input  logic             sck,
	input  logic             reset,
	input  heartPkg::sampleT filtered,
	input  logic             filteredStrobe,
	output logic             dacData,
	output logic             dacLoad
);
	import heartPkg::*;

	localparam int WordBits = $bits(dacWordT);

	dacWordT shiftReg;
	// cycles since the word was loaded, 0 when idle
	logic [3:0] bitCount;

	// MSB of the word is on the line
	assign dacData = shiftReg[WordBits-1];

	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			shiftReg <= '0;
			bitCount <= '0;
			dacLoad <= 1'b1;
		end
		else if (filteredStrobe)
		begin
			// top 8 of the 10 sample bits
			shiftReg <= {DacChannel, DacRange, filtered[$bits(sampleT)-1:2]};
			bitCount <= 4'd1;
			dacLoad <= 1'b1;
		end
		else
		begin
			// zeros follow the last bit
			shiftReg <= shiftReg << 1;
			if (bitCount == 4'(WordBits))
			begin
				// 12th cycle after load is the low one
				dacLoad <= 1'b0;
				bitCount <= bitCount + 1'b1;
			end
			else if (bitCount == 4'(WordBits + 1))
			begin
				dacLoad <= 1'b1;
				bitCount <= '0;
			end
			else if (bitCount != '0)
				bitCount <= bitCount + 1'b1;
		end
	end

endmodule

// File: verilog/rateCounter.sv
// peak counter over a fixed sample window
// reports peaks times BeatScale as beats per minute
module rateCounter #(
	parameter int MeasureLen = 2000,
	parameter int BeatScale  = 6
) (
	input  logic           sck,
	input  logic           reset,
	input  logic           filteredStrobe,
	input  logic           peakStrobe,
	output heartPkg::rateT heartRate,
	output logic           rateStrobe
);
	import heartPkg::*;

	localparam int SampleW = $clog2(MeasureLen);
	localparam int PeakW = $clog2(MeasureLen + 1);

	logic [SampleW-1:0] sampleCount;
	logic [PeakW-1:0] peakCount;
	// this strobe closes the window
	logic windowEnd;

	assign windowEnd = filteredStrobe && (sampleCount == SampleW'(MeasureLen - 1));

	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			sampleCount <= '0;
			peakCount <= '0;
			rateStrobe <= 1'b0;
		end
		else
		begin
			rateStrobe <= windowEnd;
			if (windowEnd)
			begin
				sampleCount <= '0;
				// a coincident peak opens the next window
				peakCount <= PeakW'(peakStrobe);
			end
			else
			begin
				if (filteredStrobe)
					sampleCount <= sampleCount + 1'b1;
				if (peakStrobe)
					peakCount <= peakCount + 1'b1;
			end
		end
	end

	always_ff @(posedge sck)
	begin
		if (windowEnd)
			heartRate <= rateT'(peakCount) * rateT'(BeatScale);
	end

endmodule

// File: verilog/peakDetector.sv
// slope-window peak detector with hold-off
// compares falling-slope counts in the older and newer window halves
module peakDetector #(
	parameter int WindowLen  = 256,
	parameter int RiseLimit  = 60,
	parameter int FallLimit  = 60,
	parameter int HoldoffLen = 256
) (
	input  logic             sck,
	input  logic             reset,
	input  heartPkg::sampleT filtered,
	input  logic             filteredStrobe,
	output logic             peakStrobe,
	output logic             peakLed
);
	import heartPkg::*;

	localparam int Half = WindowLen / 2;
	localparam int SumW = $clog2(Half + 1);
	localparam int HoldW = $clog2(HoldoffLen + 1);
	localparam logic [SumW-1:0] RiseMax = SumW'(RiseLimit);
	localparam logic [SumW-1:0] FallMin = SumW'(FallLimit);

	sampleT prevSample;
	// 1 = not rising, bit 0 is the newest
	logic [WindowLen-1:0] window;
	// newer half
	logic [SumW-1:0] rightSum;
	// older half
	logic [SumW-1:0] leftSum;
	logic [HoldW-1:0] holdCount;
	logic slopeBit;
	logic isPeak;

	assign slopeBit = (filtered <= prevSample);

	// mostly rising before, mostly falling after, and not in hold-off
	assign isPeak = (leftSum <= RiseMax) && (rightSum >= FallMin) && (holdCount == '0);

	// led lit for the whole hold-off
	assign peakLed = (holdCount != '0);

	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			prevSample <= '0;
			window <= '1;
			rightSum <= SumW'(Half);
			leftSum <= SumW'(Half);
			holdCount <= '0;
			peakStrobe <= 1'b0;
		end
		else
		begin
			peakStrobe <= 1'b0;
			if (filteredStrobe)
			begin
				prevSample <= filtered;
				window <= {window[WindowLen-2:0], slopeBit};
				// bit crossing the middle moves from right to left half
				rightSum <= rightSum + SumW'(slopeBit) - SumW'(window[Half-1]);
				leftSum <= leftSum + SumW'(window[Half-1]) - SumW'(window[WindowLen-1]);
				if (isPeak)
				begin
					peakStrobe <= 1'b1;
					holdCount <= HoldW'(HoldoffLen);
				end
				else if (holdCount != '0)
					holdCount <= holdCount - 1'b1;
			end
		end
	end

endmodule

// File: verilog/firFilter.sv
// 31-tap symmetric FIR low-pass filter
// delay line, pairwise multiply-accumulate, scaling and saturation
module firFilter (
	input  logic             sck,
	input  logic             reset,
	input  heartPkg::sampleT sample,
	input  logic             sampleStrobe,
	output heartPkg::sampleT filtered,
	output logic             filteredStrobe
);
	import heartPkg::*;

	// delay line, newest sample in the last entry
	sampleT taps [NumTaps];
	// delay line as it will be after this strobe
	sampleT nextTaps [NumTaps];
	accT acc;
	accT scaled;
	sampleT result;

	// next tap line
	always_comb
	begin
		for (int i = 0; i < NumTaps - 1; i++)
		begin
			nextTaps[i] = taps[i + 1];
		end
		nextTaps[NumTaps - 1] = sample;
	end

	// mirrored taps share a coefficient
	always_comb
	begin
		acc = '0;
		for (int k = 0; k < NumCoeffs - 1; k++)
		begin
			acc = acc + accT'(FilterCoeffs[k])
				* (accT'(nextTaps[k]) + accT'(nextTaps[NumTaps - 1 - k]));
		end
		// centre tap counted once
		acc = acc + accT'(FilterCoeffs[NumCoeffs - 1]) * accT'(nextTaps[NumCoeffs - 1]);
	end

	// undo the 2^10 coefficient scale
	assign scaled = acc >> FilterShift;

	// gain is slightly above one, clip at full scale
	always_comb
	begin
		if (|scaled[$bits(accT)-1:$bits(sampleT)])
			result = '1;
		else
			result = scaled[$bits(sampleT)-1:0];
	end

	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			taps <= '{default: '0};
			filteredStrobe <= 1'b0;
		end
		else
		begin
			filteredStrobe <= sampleStrobe;
			if (sampleStrobe)
				taps <= nextTaps;
		end
	end

	// previous result held until the next strobe
	always_ff @(posedge sck)
	begin
		if (sampleStrobe)
			filtered <= result;
	end

endmodule

// File: verilog/sampleReceiver.sv
// serial frame receiver
// shifts in 16-bit frames MSB first, emits the low 10 bits once per frame
module sampleReceiver (
	input  logic             sck,
	input  logic             reset,
	input  logic             sdo,
	output heartPkg::sampleT sample,
	output logic             sampleStrobe
);
	import heartPkg::*;

	localparam int CountW = $clog2(FrameLen);

	// position within the current frame
	logic [CountW-1:0] frameCount;
	frameWordT shiftReg;
	// frame including the bit sampled this cycle
	frameWordT frame;

	assign frame = {shiftReg[$bits(frameWordT)-2:0], sdo};

	// counter starts at zero on the first clock out of reset
	always_ff @(posedge sck, posedge reset)
	begin
		if (reset)
		begin
			frameCount <= '0;
			sampleStrobe <= 1'b0;
		end
		else
		begin
			frameCount <= frameCount + 1'b1;
			// 16th bit sampled now, strobe next cycle
			sampleStrobe <= (frameCount == CountW'(FrameLen - 1));
		end
	end

	// shift register and sample latch
	always_ff @(posedge sck)
	begin
		shiftReg <= frame;
		if (frameCount == CountW'(FrameLen - 1))
			sample <= frame[$bits(sampleT)-1:0];
	end

endmodule

// File: verilog/heartPkg.sv
// shared widths and types for the heart-rate monitor
// filter coefficients and seven-segment patterns
package heartPkg;

	// raw or filtered sample
	typedef logic [9:0] sampleT;
	// one received serial frame
	typedef logic [15:0] frameWordT;
	// filter accumulator, wide enough for 1023 * 1028
	typedef logic [20:0] accT;
	// beats per minute
	typedef logic [11:0] rateT;
	// active-low segments, g down to a
	typedef logic [6:0] segT;
	typedef logic [3:0] bcdT;
	// channel, range, data
	typedef logic [10:0] dacWordT;

	// clock cycles per serial frame
	localparam int FrameLen = 16;

	localparam int NumTaps = 31;
	// symmetric filter, so only half the taps plus the centre
	localparam int NumCoeffs = (NumTaps + 1) / 2;
	// low-pass coefficients scaled by 2^10, centre tap last
	localparam logic [6:0] FilterCoeffs [NumCoeffs] = '{
		7'd3, 7'd4, 7'd6, 7'd8, 7'd12, 7'd17, 7'd23, 7'd29,
		7'd36, 7'd43, 7'd50, 7'd56, 7'd61, 7'd65, 7'd67, 7'd68
	};
	localparam int FilterShift = 10;

	// DAC channel A, 1x range
	localparam logic [1:0] DacChannel = 2'b00;
	localparam logic DacRange = 1'b0;

	// digits 0 to 9
	localparam segT SegTable [10] = '{
		7'b100_0000, 7'b111_1001, 7'b010_0100, 7'b011_0000, 7'b001_1001,
		7'b001_0010, 7'b000_0010, 7'b111_1000, 7'b000_0000, 7'b001_1000
	};

endpackage
